// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it; pass only if the log shows the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --top-module matmul_tb -Mdir obj_dir -f sim.f; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vmatmul_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" "$LOG"; then
    exit 0
fi

echo "Pass line not found in $LOG"
exit 1

// ==== sim.f ====
src/matmul_pkg.sv
src/processing_element.sv
src/pe_array.sv
src/matmul_control.sv
src/cycle_counter.sv
src/operand_feeder.sv
src/result_shifter.sv
src/matmul_top.sv
sim/tb_clock.sv
sim/matmul_tb_asserts.sv
sim/matmul_tb.sv

// ==== sim/matmul_tb.sv ====
`default_nettype none

module matmul_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import matmul_pkg::*;

    localparam int MEM_WORDS    = 1 << ADDR_WIDTH;
    localparam int NUM_ROWS     = 6;
    localparam int RESET_CYCLES = 16;
    localparam int WAIT_LIMIT   = 64;

    // Cycles from the edge that samples start to the edge that samples the first beat
    localparam int FIRST_BEAT_CYCLES = CAPTURE_COUNT + 2;

    typedef enum logic [1:0] {PAT_IDENTITY, PAT_MAX, PAT_RANDOM} pattern_t;

    typedef struct packed {
        pattern_t    kind;
        matmul_cfg_t cfg;
    } test_row_t;

    logic         clk;
    logic         reset;
    logic         start;
    matmul_cfg_t  cfg;
    lane_vec_t    a_data;
    lane_vec_t    b_data;
    logic         mem_rd;
    addr_t        a_addr;
    addr_t        b_addr;
    result_beat_t result;
    logic         done;

    lane_vec_t   mem_a [MEM_WORDS];
    lane_vec_t   mem_b [MEM_WORDS];
    test_row_t   test_table [NUM_ROWS];
    data_t       mat_a [ARRAY_SIZE][ARRAY_SIZE];
    data_t       mat_b [ARRAY_SIZE][ARRAY_SIZE];
    lane_vec_t   expected_cols [ARRAY_SIZE];
    logic [31:0] rng_state;
    logic        aborted;
    int          value_errors;
    int          addr_errors;
    int          bit_errors;
    int          timeout_errors;

    tb_clock clock_inst (.clk(clk));

    matmul_top matmul_top_inst (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .cfg    (cfg),
        .a_data (a_data),
        .b_data (b_data),
        .mem_rd (mem_rd),
        .a_addr (a_addr),
        .b_addr (b_addr),
        .result (result),
        .done   (done)
    );

    //////////////////////////////////////////////////
    // Helpers and reference model
    //////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic data_t random_byte();
        rng_state = lcg_next(rng_state);
        return rng_state[31:24];
    endfunction

    function automatic addr_t strided_addr(input addr_t base, input stride_t stride, input int step);
        return addr_t'(int'(base) + step * int'(stride));
    endfunction

    function automatic test_row_t make_row(input pattern_t kind, input addr_t aa, input addr_t ab,
                                           input addr_t ac, input stride_t sa, input stride_t sb,
                                           input stride_t sc);
        test_row_t row;
        row.kind         = kind;
        row.cfg.addr_a   = aa;
        row.cfg.addr_b   = ab;
        row.cfg.addr_c   = ac;
        row.cfg.stride_a = sa;
        row.cfg.stride_b = sb;
        row.cfg.stride_c = sc;
        return row;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_lane_vec(input string name, input lane_vec_t exp, input lane_vec_t act);
        if (act !== exp)
        begin
            value_errors++;
            $display("Fail at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp)
        begin
            addr_errors++;
            $display("Fail at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            bit_errors++;
            $display("Fail at %0t ns: %s expected %b, actual %b", $time, name, exp, act);
        end
    endtask

    task automatic expect_outputs_idle();
        check_bit("mem_rd", 1'b0, mem_rd);
        check_bit("result.valid", 1'b0, result.valid);
        check_bit("done", 1'b0, done);
    endtask

    // Word k of A holds column k, word k of B holds row k
    task automatic load_operands(input test_row_t row);
        lane_vec_t a_word;
        lane_vec_t b_word;
        for (int i = 0; i < ARRAY_SIZE; i++)
        begin
            for (int k = 0; k < ARRAY_SIZE; k++)
            begin
                if (row.kind == PAT_IDENTITY)
                begin
                    mat_a[i][k] = (i == k) ? 8'd1 : 8'd0;
                    mat_b[i][k] = random_byte();
                end
                else if (row.kind == PAT_MAX)
                begin
                    mat_a[i][k] = 8'hff;
                    mat_b[i][k] = 8'hff;
                end
                else
                begin
                    mat_a[i][k] = random_byte();
                    mat_b[i][k] = random_byte();
                end
            end
        end
        for (int k = 0; k < ARRAY_SIZE; k++)
        begin
            for (int i = 0; i < ARRAY_SIZE; i++)
            begin
                a_word[i] = mat_a[i][k];
                b_word[i] = mat_b[k][i];
            end
            mem_a[strided_addr(row.cfg.addr_a, row.cfg.stride_a, k)] = a_word;
            mem_b[strided_addr(row.cfg.addr_b, row.cfg.stride_b, k)] = b_word;
        end
    endtask

    // C[i][j] is the sum over k of A[i][k]*B[k][j], kept to eight bits
    task automatic compute_expected();
        data_t sum;
        for (int j = 0; j < ARRAY_SIZE; j++)
        begin
            for (int i = 0; i < ARRAY_SIZE; i++)
            begin
                sum = 8'd0;
                for (int k = 0; k < ARRAY_SIZE; k++)
                    sum = sum + data_t'(16'(mat_a[i][k]) * 16'(mat_b[k][j]));
                expected_cols[j][i] = sum;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // One run of the tile
    //////////////////////////////////////////////////

    task automatic run_row(input test_row_t row);
        int waited;
        load_operands(row);
        compute_expected();
        cfg   = row.cfg;
        start = 1'b1;
        waited = 0;
        // Reads go out on the first ARRAY_SIZE cycles, the first beat follows at a fixed latency
        do
        begin
            next_cycle();
            waited++;
            check_bit("mem_rd", waited <= ARRAY_SIZE, mem_rd);
            if (waited <= ARRAY_SIZE)
            begin
                check_addr("a_addr", strided_addr(row.cfg.addr_a, row.cfg.stride_a, waited - 1),
                           a_addr);
                check_addr("b_addr", strided_addr(row.cfg.addr_b, row.cfg.stride_b, waited - 1),
                           b_addr);
            end
            check_bit("result.valid", waited == FIRST_BEAT_CYCLES, result.valid);
        end
        while (!result.valid && waited < WAIT_LIMIT);
        if (!result.valid)
        begin
            $display("Timeout: no result beat within %0d cycles of start", WAIT_LIMIT);
            timeout_errors++;
            aborted = 1'b1;
            return;
        end
        for (int j = 0; j < ARRAY_SIZE; j++)
        begin
            if (j != 0)
                next_cycle();
            check_bit("result.valid", 1'b1, result.valid);
            check_lane_vec("result.data", expected_cols[j], result.data);
            check_addr("result.addr", strided_addr(row.cfg.addr_c, row.cfg.stride_c, j),
                       result.addr);
            check_bit("done", 1'b0, done);
        end
        next_cycle();
        check_bit("result.valid", 1'b0, result.valid);
        check_bit("done", 1'b1, done);
        waited = 0;
        while (!done && waited < WAIT_LIMIT)
        begin
            next_cycle();
            waited++;
        end
        if (!done)
        begin
            $display("Timeout: done never came after the last result beat");
            timeout_errors++;
            aborted = 1'b1;
            return;
        end
        next_cycle();
        check_bit("done", 1'b0, done);
        start = 1'b0;
        next_cycle();
        expect_outputs_idle();
    endtask

    // Memories drive the addressed word every cycle, and it is meaningful
    // only one cycle after a read. Inputs change 1 ns after the edge
    initial
    begin
        lane_vec_t a_word;
        lane_vec_t b_word;
        a_data = '0;
        b_data = '0;
        forever
        begin
            @(posedge clk);
            a_word = mem_a[a_addr];
            b_word = mem_b[b_addr];
            #1;
            a_data = a_word;
            b_data = b_word;
        end
    end

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial
    begin
        rng_state      = 32'h296302ac;
        reset          = 1'b1;
        start          = 1'b0;
        cfg            = '0;
        aborted        = 1'b0;
        value_errors   = 0;
        addr_errors    = 0;
        bit_errors     = 0;
        timeout_errors = 0;
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            mem_a[i] = lane_vec_t'(i * 32'h9e3779b1);
            mem_b[i] = lane_vec_t'((i ^ 32'h2aa) * 32'h85ebca6b);
        end
        test_table[0] = make_row(PAT_IDENTITY, 10'h000, 10'h100, 10'h200, 8'd1, 8'd1, 8'd1);
        test_table[1] = make_row(PAT_RANDOM, 10'h013, 10'h127, 10'h23b, 8'd3, 8'd3, 8'd3);
        test_table[2] = make_row(PAT_RANDOM, 10'h055, 10'h1aa, 10'h2f0, 8'd7, 8'd7, 8'd7);
        test_table[3] = make_row(PAT_MAX, 10'h300, 10'h040, 10'h380, 8'd1, 8'd3, 8'd7);
        test_table[4] = make_row(PAT_RANDOM, 10'h3fe, 10'h200, 10'h001, 8'd7, 8'd1, 8'd3);
        test_table[5] = make_row(PAT_RANDOM, 10'h123, 10'h0ff, 10'h3c0, 8'hff, 8'h80, 8'h10);

        for (int c = 0; c < RESET_CYCLES; c++)
        begin
            next_cycle();
            expect_outputs_idle();
        end
        reset = 1'b0;
        for (int c = 0; c < 4; c++)
        begin
            next_cycle();
            expect_outputs_idle();
        end

        for (int r = 0; r < NUM_ROWS && !aborted; r++)
            run_row(test_table[r]);

        $display("Errors: data %0d, address %0d, control %0d, timeout %0d",
                 value_errors, addr_errors, bit_errors, timeout_errors);
        if (value_errors + addr_errors + bit_errors + timeout_errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/matmul_tb_asserts.sv ====
`default_nettype none

module matmul_tb_asserts (
    input logic                     clk,
    input logic                     reset,
    input logic                     mem_rd,
    input matmul_pkg::result_beat_t result,
    input logic                     done
);
    timeunit 1ns;
    timeprecision 1ps;
    import matmul_pkg::*;

    // Number of consecutive high cycles seen so far, up to the last edge
    logic [2:0] rd_run;
    logic [2:0] valid_run;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_run    <= '0;
            valid_run <= '0;
        end
        else
        begin
            rd_run    <= mem_rd ? rd_run + 3'd1 : 3'd0;
            valid_run <= result.valid ? valid_run + 3'd1 : 3'd0;
        end
    end

    done_single: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else $error("done stayed high for more than one cycle");

    valid_too_long: assert property (@(posedge clk) disable iff (reset)
        result.valid |-> valid_run < 3'd4)
        else $error("result.valid high for more than four cycles");

    valid_too_short: assert property (@(posedge clk) disable iff (reset)
        $fell(result.valid) |-> valid_run == 3'd4)
        else $error("result.valid burst shorter than four cycles");

    rd_too_long: assert property (@(posedge clk) disable iff (reset)
        mem_rd |-> rd_run < 3'd4)
        else $error("mem_rd high for more than four cycles");

    rd_too_short: assert property (@(posedge clk) disable iff (reset)
        $fell(mem_rd) |-> rd_run == 3'd4)
        else $error("mem_rd burst shorter than four cycles");

    // The first edge of reset still sees power-up values, so skip it
    quiet_in_reset: assert property (@(posedge clk)
        (reset && $past(reset)) |-> (!mem_rd && !result.valid && !done))
        else $error("control output high during reset");

endmodule

bind matmul_top matmul_tb_asserts matmul_tb_asserts_inst (
    .clk    (clk),
    .reset  (reset),
    .mem_rd (mem_rd),
    .result (result),
    .done   (done)
);

`default_nettype wire

// ==== sim/tb_clock.sv ====
`default_nettype none

module tb_clock (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    // Half period of 2 ns gives the 4 ns clock
    initial
    begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

endmodule

`default_nettype wire

// ==== src/cycle_counter.sv ====
`default_nettype none

module cycle_counter (
    input  logic clk,
    input  logic reset,
    input  logic run,
    output logic fetch_active,
    output logic capture,
    output logic finish
);
    import matmul_pkg::*;

    localparam int COUNT_WIDTH = $clog2(FINISH_COUNT + 1);

    logic [COUNT_WIDTH-1:0] count;

    // Count restarts on finish so it already reads zero in ST_DONE
    always_ff @(posedge clk)
    begin
        if (reset || !run || finish)
        begin
            count <= '0;
        end
        else
        begin
            count <= count + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Phase decode
    //////////////////////////////////////////////////

    // Count is also zero outside a run, hence the extra run term here
    assign fetch_active = run && (count < COUNT_WIDTH'(ARRAY_SIZE));

    assign capture = (count == COUNT_WIDTH'(CAPTURE_COUNT));
    assign finish  = (count == COUNT_WIDTH'(FINISH_COUNT));

endmodule

`default_nettype wire

// ==== src/matmul_control.sv ====
`default_nettype none

module matmul_control (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic finish,
    output logic run,
    output logic array_clear,
    output logic done
);
    import matmul_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;

    always_comb
    begin
        state_next = state;
        case (state)
            ST_IDLE:
            begin
                if (start)
                    state_next = ST_RUN;
            end
            ST_RUN:
            begin
                if (finish)
                    state_next = ST_DONE;
            end
            ST_DONE:
                state_next = ST_WAIT_LOW;
            // Hold here so that a start still held high does not retrigger
            ST_WAIT_LOW:
            begin
                if (!start)
                    state_next = ST_IDLE;
            end
            default:
                state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= ST_IDLE;
            done  <= 1'b0;
        end
        else
        begin
            state <= state_next;
            // One cycle behind ST_DONE, so done lands just after the last result beat
            done  <= (state == ST_DONE);
        end
    end

    assign run = (state == ST_RUN);

    // Accumulators sit at zero whenever the tile waits for a new start
    assign array_clear = (state == ST_IDLE);

endmodule

`default_nettype wire

// ==== src/matmul_pkg.sv ====
`default_nettype none

package matmul_pkg;

    localparam int ARRAY_SIZE   = 4;
    localparam int DATA_WIDTH   = 8;
    localparam int ADDR_WIDTH   = 10;
    localparam int STRIDE_WIDTH = 8;
    localparam int MAC_LATENCY  = 3;

    // The far cell takes its last operands at count 3*N-2 and its sum settles
    // MAC_LATENCY cycles later. The result is captured one cycle after that
    localparam int CAPTURE_COUNT = 3 * ARRAY_SIZE + MAC_LATENCY - 1;
    localparam int FINISH_COUNT  = CAPTURE_COUNT + ARRAY_SIZE - 1;

    typedef logic [DATA_WIDTH-1:0]   data_t;
    typedef logic [ADDR_WIDTH-1:0]   addr_t;
    typedef logic [STRIDE_WIDTH-1:0] stride_t;

    // Lane i is element i of a memory word or of a result column
    typedef data_t [ARRAY_SIZE-1:0] lane_vec_t;
    typedef lane_vec_t [ARRAY_SIZE-1:0] result_mat_t;

    typedef struct packed {
        addr_t   addr_a;
        addr_t   addr_b;
        addr_t   addr_c;
        stride_t stride_a;
        stride_t stride_b;
        stride_t stride_c;
    } matmul_cfg_t;

    typedef struct packed {
        logic      valid;
        addr_t     addr;
        lane_vec_t data;
    } result_beat_t;

    typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_DONE, ST_WAIT_LOW} ctrl_state_t;

endpackage

`default_nettype wire

// ==== src/matmul_top.sv ====
`default_nettype none

module matmul_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  matmul_pkg::matmul_cfg_t  cfg,
    input  matmul_pkg::lane_vec_t    a_data,
    input  matmul_pkg::lane_vec_t    b_data,
    output logic                     mem_rd,
    output matmul_pkg::addr_t        a_addr,
    output matmul_pkg::addr_t        b_addr,
    output matmul_pkg::result_beat_t result,
    output logic                     done
);
    import matmul_pkg::*;

    logic        run;
    logic        array_clear;
    logic        fetch_active;
    logic        capture;
    logic        finish;
    lane_vec_t   a_skewed;
    lane_vec_t   b_skewed;
    result_mat_t c_mat;

    //////////////////////////////////////////////////
    // Sequencing
    //////////////////////////////////////////////////

    matmul_control control_inst (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .finish      (finish),
        .run         (run),
        .array_clear (array_clear),
        .done        (done)
    );

    cycle_counter counter_inst (
        .clk          (clk),
        .reset        (reset),
        .run          (run),
        .fetch_active (fetch_active),
        .capture      (capture),
        .finish       (finish)
    );

    //////////////////////////////////////////////////
    // Data path
    //////////////////////////////////////////////////

    operand_feeder feeder_inst (
        .clk          (clk),
        .reset        (reset),
        .fetch_active (fetch_active),
        .cfg          (cfg),
        .a_data       (a_data),
        .b_data       (b_data),
        .mem_rd       (mem_rd),
        .a_addr       (a_addr),
        .b_addr       (b_addr),
        .a_skewed     (a_skewed),
        .b_skewed     (b_skewed)
    );

    pe_array array_inst (
        .clk   (clk),
        .reset (reset),
        .clear (array_clear),
        .a_in  (a_skewed),
        .b_in  (b_skewed),
        .c_mat (c_mat)
    );

    result_shifter shifter_inst (
        .clk     (clk),
        .reset   (reset),
        .capture (capture),
        .cfg     (cfg),
        .c_mat   (c_mat),
        .result  (result)
    );

endmodule

`default_nettype wire

// ==== src/operand_feeder.sv ====
`default_nettype none

module operand_feeder (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    fetch_active,
    input  matmul_pkg::matmul_cfg_t cfg,
    input  matmul_pkg::lane_vec_t   a_data,
    input  matmul_pkg::lane_vec_t   b_data,
    output logic                    mem_rd,
    output matmul_pkg::addr_t       a_addr,
    output matmul_pkg::addr_t       b_addr,
    output matmul_pkg::lane_vec_t   a_skewed,
    output matmul_pkg::lane_vec_t   b_skewed
);
    import matmul_pkg::*;

    logic      data_valid;
    lane_vec_t qualified [2];
    lane_vec_t skewed [2];

    //////////////////////////////////////////////////
    // Strided read addresses
    //////////////////////////////////////////////////

    assign mem_rd = fetch_active;

    // Addresses rest at the base, so the first read of a run uses it directly
    always_ff @(posedge clk)
    begin
        if (!fetch_active)
        begin
            a_addr <= cfg.addr_a;
            b_addr <= cfg.addr_b;
        end
        else
        begin
            a_addr <= a_addr + addr_t'(cfg.stride_a);
            b_addr <= b_addr + addr_t'(cfg.stride_b);
        end
    end

    // Memory answers one cycle after each read
    always_ff @(posedge clk)
    begin
        if (reset)
            data_valid <= 1'b0;
        else
            data_valid <= mem_rd;
    end

    assign qualified[0] = data_valid ? a_data : '0;
    assign qualified[1] = data_valid ? b_data : '0;

    //////////////////////////////////////////////////
    // Systolic skew
    //////////////////////////////////////////////////

    // Index 0 is the A path, index 1 the B path. Lane i goes through i stages
    for (genvar op = 0; op < 2; op++)
    begin : g_operand
        for (genvar i = 0; i < ARRAY_SIZE; i++)
        begin : g_lane
            if (i == 0)
            begin : g_direct
                assign skewed[op][i] = qualified[op][i];
            end
            else
            begin : g_delay
                data_t taps [i];

                always_ff @(posedge clk)
                begin
                    taps[0] <= qualified[op][i];
                    for (int t = 1; t < i; t++)
                        taps[t] <= taps[t-1];
                end

                assign skewed[op][i] = taps[i-1];
            end
        end
    end

    assign a_skewed = skewed[0];
    assign b_skewed = skewed[1];

endmodule

`default_nettype wire

// ==== src/pe_array.sv ====
`default_nettype none

module pe_array (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    clear,
    input  matmul_pkg::lane_vec_t   a_in,
    input  matmul_pkg::lane_vec_t   b_in,
    output matmul_pkg::result_mat_t c_mat
);
    import matmul_pkg::*;

    // a_link[i][j] enters cell (i,j) from the left, b_link[i][j] from above.
    // Column ARRAY_SIZE of a_link and row ARRAY_SIZE of b_link are the east
    // and south edge outputs, which have no load inside the tile
    data_t a_link [ARRAY_SIZE][ARRAY_SIZE+1];
    data_t b_link [ARRAY_SIZE+1][ARRAY_SIZE];

    for (genvar i = 0; i < ARRAY_SIZE; i++)
    begin : g_edge
        assign a_link[i][0] = a_in[i];
        assign b_link[0][i] = b_in[i];
    end

    //////////////////////////////////////////////////
    // Grid of cells
    //////////////////////////////////////////////////

    for (genvar i = 0; i < ARRAY_SIZE; i++)
    begin : g_row
        for (genvar j = 0; j < ARRAY_SIZE; j++)
        begin : g_col
            processing_element pe_inst (
                .clk   (clk),
                .reset (reset),
                .clear (clear),
                .in_a  (a_link[i][j]),
                .in_b  (b_link[i][j]),
                .out_a (a_link[i][j+1]),
                .out_b (b_link[i+1][j]),
                // Cell (i,j) holds C[i][j], which is lane i of column word j
                .acc   (c_mat[j][i])
            );
        end
    end

endmodule

`default_nettype wire

// ==== src/processing_element.sv ====
`default_nettype none

module processing_element (
    input  logic              clk,
    input  logic              reset,
    input  logic              clear,
    input  matmul_pkg::data_t in_a,
    input  matmul_pkg::data_t in_b,
    output matmul_pkg::data_t out_a,
    output matmul_pkg::data_t out_b,
    output matmul_pkg::data_t acc
);
    import matmul_pkg::*;

    data_t product;

    // The forwarding registers double as the first MAC stage,
    // then product and accumulate make three stages in total
    always_ff @(posedge clk)
    begin
        if (reset || clear)
        begin
            out_a   <= '0;
            out_b   <= '0;
            product <= '0;
            acc     <= '0;
        end
        else
        begin
            out_a   <= in_a;
            out_b   <= in_b;
            // Only the low byte of the product is kept
            product <= out_a * out_b;
            acc     <= acc + product;
        end
    end

endmodule

`default_nettype wire

// ==== src/result_shifter.sv ====
`default_nettype none

module result_shifter (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     capture,
    input  matmul_pkg::matmul_cfg_t  cfg,
    input  matmul_pkg::result_mat_t  c_mat,
    output matmul_pkg::result_beat_t result
);
    import matmul_pkg::*;

    localparam int BEAT_WIDTH = $clog2(ARRAY_SIZE);

    result_mat_t           pending;
    logic [BEAT_WIDTH-1:0] beats_left;
    logic                  beat_valid;
    addr_t                 beat_addr;
    lane_vec_t             beat_data;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            beat_valid <= 1'b0;
            beats_left <= '0;
        end
        else if (capture)
        begin
            beat_valid <= 1'b1;
            beats_left <= BEAT_WIDTH'(ARRAY_SIZE - 1);
        end
        else if (beats_left != '0)
        begin
            beats_left <= beats_left - 1'b1;
        end
        else
        begin
            beat_valid <= 1'b0;
        end
    end

    // Column 0 goes out straight from the capture, the rest shift down one per beat
    always_ff @(posedge clk)
    begin
        if (capture)
        begin
            pending   <= c_mat;
            beat_data <= c_mat[0];
            beat_addr <= cfg.addr_c;
        end
        else if (beats_left != '0)
        begin
            pending   <= {lane_vec_t'('0), pending[ARRAY_SIZE-1:1]};
            beat_data <= pending[1];
            beat_addr <= beat_addr + addr_t'(cfg.stride_c);
        end
    end

    assign result = '{valid: beat_valid, addr: beat_addr, data: beat_data};

endmodule

`default_nettype wire
